// ==== zip_bus_pkg.sv ====
////////////////////
// Bus package for the CPU memory side
// Widths, word and address types, memory operation codes
// and the local-bus address prefix shared by all units
////////////////////

package zip_bus_pkg;

	////////////////////
	// Widths
	////////////////////

	// Data bus width in bits
	localparam int DW = 32;
	// One select bit per byte lane
	localparam int SEL_W = DW / 8;
	// Word address, byte address without the two low bits
	localparam int WB_AW = 30;

	////////////////////
	// Types
	////////////////////

	// Data or instruction word
	typedef logic [DW-1:0] word_t;
	// CPU byte address
	typedef logic [31:0] byte_addr_t;
	// Wishbone word address
	typedef logic [WB_AW-1:0] wb_addr_t;
	// Byte selects, bit 3 is byte offset 0 (big-endian)
	typedef logic [SEL_W-1:0] sel_t;
	// Destination register of a load
	typedef logic [4:0] reg_id_t;

	// Memory operations from the core
	typedef enum logic [2:0] {
		MEM_LW,
		MEM_LH,
		MEM_LB,
		MEM_SW,
		MEM_SH,
		MEM_SB
	} mem_op_t;

	////////////////////
	// Constants
	////////////////////

	// Top address byte of the local bus region
	localparam logic [7:0] LCL_PREFIX = 8'hff;
	// PC step per instruction
	localparam int INSN_BYTES = 4;

endpackage

// ==== zip_wb_if.sv ====
////////////////////
// Wishbone master link
// One master and its side of the arbiter, single-word cycles
////////////////////

`timescale 1ns/1ns

interface zip_wb_if;

	// Master side of the link
	logic			cyc;
	logic			stb;
	logic			lcl;
	logic			we;
	zip_bus_pkg::wb_addr_t	addr;
	zip_bus_pkg::word_t	data;
	zip_bus_pkg::sel_t	sel;

	// Returned by the arbiter
	logic			stall;
	logic			ack;
	logic			err;
	zip_bus_pkg::word_t	idata;

	// Data unit, reads and writes either bus
	modport data_master (
		output cyc, stb, lcl, we, addr, data, sel,
		input  stall, ack, err, idata
	);

	// Fetch unit, global reads only
	modport fetch_master (
		output cyc, stb, addr,
		input  stall, ack, err, idata
	);

	// Arbiter ends of the two links
	modport data_arb (
		input  cyc, stb, lcl, we, addr, data, sel,
		output stall, ack, err, idata
	);
	modport fetch_arb (
		input  cyc, stb, addr,
		output stall, ack, err, idata
	);

endinterface

// ==== zip_prefetch.sv ====
////////////////////
// Single-word instruction prefetch
// Fetches one word per bus cycle, holds it until the core takes it,
// then moves on to the next word; restarts on a new PC
////////////////////

`timescale 1ns/1ns

module zip_prefetch (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_new_pc,
	input	zip_bus_pkg::byte_addr_t	i_pc,
	input	logic				i_ready,
	output	logic				o_valid,
	output	logic				o_illegal,
	output	zip_bus_pkg::word_t		o_insn,
	output	zip_bus_pkg::byte_addr_t	o_pc,
	zip_wb_if.fetch_master			bus
);
	import zip_bus_pkg::*;

	// PC of the word being fetched, or the next one to fetch
	byte_addr_t	req_pc;
	byte_addr_t	next_pc;
	byte_addr_t	start_pc;
	// New PC seen during a bus cycle, fetch once the cycle ends
	logic		req_pend;
	// Result of the current cycle is stale
	logic		invalid;
	logic		bus_done;
	logic		capture;
	logic		consume;
	logic		start;

	assign next_pc = req_pc + byte_addr_t'(INSN_BYTES);
	assign bus_done = bus.cyc && (bus.ack || bus.err);
	// Keep the word only if nothing redirected the fetch
	assign capture = bus_done && !invalid && !i_new_pc;
	// Core takes the held word
	assign consume = !bus.cyc && !i_new_pc && !req_pend && o_valid && i_ready;
	// After an illegal word, wait for a new PC
	assign start = !bus.cyc && (i_new_pc || req_pend || (consume && !o_illegal));

	always_comb
	begin
		if (i_new_pc)
			start_pc = i_pc;
		else if (req_pend)
			start_pc = req_pc;
		else
			start_pc = next_pc;
	end

	////////////////////
	// Bus and handshake control
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			req_pend <= 1'b0;
			invalid <= 1'b0;
			o_valid <= 1'b0;
			o_illegal <= 1'b0;
		end else begin
			if (start)
			begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
			end else if (bus_done)
			begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
			end else if (!bus.stall)
				bus.stb <= 1'b0;

			// Redirect while a cycle is out
			if (bus_done)
				invalid <= 1'b0;
			else if (bus.cyc && i_new_pc)
				invalid <= 1'b1;
			if (start)
				req_pend <= 1'b0;
			else if (bus.cyc && i_new_pc)
				req_pend <= 1'b1;

			// Held result, cleared by a new PC or by the core
			if (i_new_pc || consume)
				o_valid <= 1'b0;
			else if (capture)
				o_valid <= 1'b1;
			if (capture)
				o_illegal <= bus.err;
		end
	end

	// Addresses and the fetched word
	always_ff @(posedge i_clk)
	begin
		if (i_new_pc)
			req_pc <= i_pc;
		else if (consume)
			req_pc <= next_pc;
		if (start)
			bus.addr <= start_pc[31:2];
		if (capture)
		begin
			o_insn <= bus.idata;
			o_pc <= req_pc;
		end
	end

	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		bus.stb |-> bus.cyc);
	a_valid_after_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(o_valid) |-> !bus.cyc);

endmodule

// ==== zip_memops.sv ====
////////////////////
// Single-operation memory unit
// One load or store at a time, big-endian byte lanes,
// zero-extended loads and local-bus decode by address prefix
////////////////////

`timescale 1ns/1ns

module zip_memops (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_ce,
	input	zip_bus_pkg::mem_op_t		i_op,
	input	zip_bus_pkg::byte_addr_t	i_addr,
	input	zip_bus_pkg::word_t		i_data,
	input	zip_bus_pkg::reg_id_t		i_oreg,
	output	logic				o_busy,
	output	logic				o_valid,
	output	logic				o_err,
	output	zip_bus_pkg::reg_id_t		o_wreg,
	output	zip_bus_pkg::word_t		o_result,
	zip_wb_if.data_master			bus
);
	import zip_bus_pkg::*;

	// Operation and lane kept for the load return
	mem_op_t	op_q;
	logic [1:0]	lane;
	sel_t		ce_sel;
	word_t		ce_data;
	word_t		shifted;
	word_t		load_word;
	logic		bus_done;

	assign bus_done = bus.cyc && (bus.ack || bus.err);
	// Busy for the whole bus cycle
	assign o_busy = bus.cyc;

	////////////////////
	// Byte selects and store lanes
	////////////////////
	always_comb
	begin
		case (i_op)
		MEM_LH, MEM_SH:
		begin
			ce_sel = i_addr[1] ? 4'b0011 : 4'b1100;
			ce_data = {2{i_data[15:0]}};
		end
		MEM_LB, MEM_SB:
		begin
			// Offset 0 is the top lane
			ce_sel = 4'b1000 >> i_addr[1:0];
			ce_data = {4{i_data[7:0]}};
		end
		default:
		begin
			ce_sel = '1;
			ce_data = i_data;
		end
		endcase
	end

	// Move the addressed lane down, then clear the upper bits
	always_comb
	begin
		case (op_q)
		MEM_LH:
		begin
			shifted = bus.idata >> {~lane[1], 4'b0000};
			load_word = {16'h0, shifted[15:0]};
		end
		MEM_LB:
		begin
			shifted = bus.idata >> {~lane, 3'b000};
			load_word = {24'h0, shifted[7:0]};
		end
		default:
		begin
			shifted = bus.idata;
			load_word = shifted;
		end
		endcase
	end

	////////////////////
	// Bus cycle control
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			o_valid <= 1'b0;
			o_err <= 1'b0;
		end else begin
			if (i_ce)
			begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
			end else if (bus_done)
			begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
			end else if (!bus.stall)
				bus.stb <= 1'b0;

			// Loads only report data
			o_valid <= bus.cyc && bus.ack && !bus.we;
			o_err <= bus.cyc && bus.err;
		end
	end

	// Request registers
	always_ff @(posedge i_clk)
	begin
		if (i_ce)
		begin
			bus.addr <= i_addr[31:2];
			bus.lcl <= (i_addr[31:24] == LCL_PREFIX);
			bus.we <= (i_op == MEM_SW) || (i_op == MEM_SH) || (i_op == MEM_SB);
			bus.sel <= ce_sel;
			bus.data <= ce_data;
			o_wreg <= i_oreg;
			op_q <= i_op;
			lane <= i_addr[1:0];
		end
		if (bus_done)
			o_result <= load_word;
	end

	a_no_ce_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_ce |-> !o_busy);
	a_valid_or_err: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_valid && o_err));

endmodule

// ==== zip_bus_arbiter.sv ====
////////////////////
// Data-priority bus arbiter
// Merges the data and fetch masters onto one Wishbone bus
// with global and local cycle lines, grant held per bus cycle
////////////////////

`timescale 1ns/1ns

module zip_bus_arbiter (
	input	logic				i_clk,
	input	logic				i_reset,
	zip_wb_if.data_arb			mem,
	zip_wb_if.fetch_arb			pf,
	output	logic				o_wb_gbl_cyc,
	output	logic				o_wb_gbl_stb,
	output	logic				o_wb_lcl_cyc,
	output	logic				o_wb_lcl_stb,
	output	logic				o_wb_we,
	output	zip_bus_pkg::wb_addr_t		o_wb_addr,
	output	zip_bus_pkg::word_t		o_wb_data,
	output	zip_bus_pkg::sel_t		o_wb_sel,
	input	logic				i_wb_stall,
	input	logic				i_wb_ack,
	input	logic				i_wb_err,
	input	zip_bus_pkg::word_t		i_wb_data
);
	import zip_bus_pkg::*;

	// Grant register, 1 means the data master owns the bus
	logic	held;
	logic	owner_q;
	logic	owner;
	logic	owner_cyc;

	// Free bus: data first, fetch otherwise
	assign owner = held ? owner_q : mem.cyc;
	assign owner_cyc = owner ? mem.cyc : pf.cyc;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			held <= 1'b0;
			owner_q <= 1'b0;
		end else begin
			// Released once the owner drops its cycle
			held <= owner_cyc;
			owner_q <= owner;
		end
	end

	////////////////////
	// Request mux
	////////////////////

	// Fetch is always a global read
	assign o_wb_gbl_cyc = owner ? (mem.cyc && !mem.lcl) : pf.cyc;
	assign o_wb_gbl_stb = owner ? (mem.stb && !mem.lcl) : pf.stb;
	assign o_wb_lcl_cyc = owner && mem.cyc && mem.lcl;
	assign o_wb_lcl_stb = owner && mem.stb && mem.lcl;
	assign o_wb_we = owner && mem.we;
	assign o_wb_addr = owner ? mem.addr : pf.addr;
	// Fetch never writes, so the store data passes straight through
	assign o_wb_data = mem.data;
	assign o_wb_sel = owner ? mem.sel : {SEL_W{1'b1}};

	////////////////////
	// Return paths
	////////////////////

	// The waiting master sees a stalled, silent bus
	assign mem.stall = owner ? i_wb_stall : 1'b1;
	assign mem.ack = owner && i_wb_ack;
	assign mem.err = owner && i_wb_err;
	assign mem.idata = i_wb_data;

	assign pf.stall = owner ? 1'b1 : i_wb_stall;
	assign pf.ack = !owner && i_wb_ack;
	assign pf.err = !owner && i_wb_err;
	assign pf.idata = i_wb_data;

	a_one_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_wb_gbl_cyc && o_wb_lcl_cyc));
	a_grant_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(owner != $past(owner)) |-> !$past(owner_cyc));

endmodule

// ==== zip_bus_top.sv ====
////////////////////
// CPU bus side, top level
// Prefetch and memory unit sharing one Wishbone bus
// through the data-priority arbiter
////////////////////

`timescale 1ns/1ns

module zip_bus_top (
	input	logic				i_clk,
	input	logic				i_reset,
	// Core fetch port
	input	logic				i_pf_new_pc,
	input	zip_bus_pkg::byte_addr_t	i_pf_pc,
	input	logic				i_pf_ready,
	output	logic				o_pf_valid,
	output	logic				o_pf_illegal,
	output	zip_bus_pkg::word_t		o_pf_insn,
	output	zip_bus_pkg::byte_addr_t	o_pf_pc,
	// Core memory port
	input	logic				i_mem_ce,
	input	zip_bus_pkg::mem_op_t		i_mem_op,
	input	zip_bus_pkg::byte_addr_t	i_mem_addr,
	input	zip_bus_pkg::word_t		i_mem_data,
	input	zip_bus_pkg::reg_id_t		i_mem_reg,
	output	logic				o_mem_busy,
	output	logic				o_mem_valid,
	output	logic				o_mem_err,
	output	zip_bus_pkg::reg_id_t		o_mem_wreg,
	output	zip_bus_pkg::word_t		o_mem_result,
	// Wishbone bus
	output	logic				o_wb_gbl_cyc,
	output	logic				o_wb_gbl_stb,
	output	logic				o_wb_lcl_cyc,
	output	logic				o_wb_lcl_stb,
	output	logic				o_wb_we,
	output	zip_bus_pkg::wb_addr_t		o_wb_addr,
	output	zip_bus_pkg::word_t		o_wb_data,
	output	zip_bus_pkg::sel_t		o_wb_sel,
	input	logic				i_wb_stall,
	input	logic				i_wb_ack,
	input	logic				i_wb_err,
	input	zip_bus_pkg::word_t		i_wb_data
);
	import zip_bus_pkg::*;

	// Links between the units and the arbiter
	zip_wb_if pf_bus ();
	zip_wb_if mem_bus ();

	zip_prefetch pf (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_new_pc(i_pf_new_pc), .i_pc(i_pf_pc), .i_ready(i_pf_ready),
		.o_valid(o_pf_valid), .o_illegal(o_pf_illegal),
		.o_insn(o_pf_insn), .o_pc(o_pf_pc),
		.bus(pf_bus.fetch_master)
	);

	zip_memops mem (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_ce(i_mem_ce), .i_op(i_mem_op), .i_addr(i_mem_addr),
		.i_data(i_mem_data), .i_oreg(i_mem_reg),
		.o_busy(o_mem_busy), .o_valid(o_mem_valid), .o_err(o_mem_err),
		.o_wreg(o_mem_wreg), .o_result(o_mem_result),
		.bus(mem_bus.data_master)
	);

	// Data unit takes priority over fetch
	zip_bus_arbiter arb (
		.i_clk(i_clk), .i_reset(i_reset),
		.mem(mem_bus.data_arb), .pf(pf_bus.fetch_arb),
		.o_wb_gbl_cyc(o_wb_gbl_cyc), .o_wb_gbl_stb(o_wb_gbl_stb),
		.o_wb_lcl_cyc(o_wb_lcl_cyc), .o_wb_lcl_stb(o_wb_lcl_stb),
		.o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack),
		.i_wb_err(i_wb_err), .i_wb_data(i_wb_data)
	);

endmodule

// ==== zip_wb_slave_model.sv ====
////////////////////
// Wishbone slave model for the testbench
// Global and local 256-word memories, random stalls and ack delays,
// and an error region on the global bus
////////////////////

`timescale 1ns/1ns

module zip_wb_slave_model (
	input	logic				i_clk,
	input	logic				i_reset,
	input	logic				i_gbl_cyc,
	input	logic				i_gbl_stb,
	input	logic				i_lcl_cyc,
	input	logic				i_lcl_stb,
	input	logic				i_we,
	input	zip_bus_pkg::wb_addr_t		i_addr,
	input	zip_bus_pkg::word_t		i_data,
	input	zip_bus_pkg::sel_t		i_sel,
	output	logic				o_stall,
	output	logic				o_ack,
	output	logic				o_err,
	output	zip_bus_pkg::word_t		o_data
);
	import zip_bus_pkg::*;

	word_t		gmem [0:255];
	word_t		lmem [0:255];
	// Accepted request
	logic		busy;
	logic		is_lcl;
	logic		is_err;
	logic		we_q;
	wb_addr_t	addr_q;
	word_t		data_q;
	sel_t		sel_q;
	// Stall cycles left before the next strobe is taken
	logic [1:0]	stall_left;
	// Cycles left before the ack
	logic [1:0]	wait_left;
	logic		gbl_req;
	logic		lcl_req;
	logic		stb_in;
	word_t		cur;
	word_t		merged;

	// Reset content of one memory word
	function automatic word_t fill_word(input logic lcl, input logic [7:0] idx);
		fill_word = {lcl ? 8'hc3 : 8'h3c, idx, ~idx, idx ^ 8'h96};
	endfunction

	// A strobe only counts inside its own cycle
	assign gbl_req = i_gbl_cyc && i_gbl_stb;
	assign lcl_req = i_lcl_cyc && i_lcl_stb;
	assign stb_in = gbl_req || lcl_req;
	assign o_stall = busy || (stall_left != 2'd0);

	// Addressed word and the word after the store merge
	always_comb
	begin
		cur = is_lcl ? lmem[addr_q[7:0]] : gmem[addr_q[7:0]];
		merged = cur;
		for (int b = 0; b < SEL_W; b++)
			if (sel_q[b])
				merged[8*b +: 8] = data_q[8*b +: 8];
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			busy <= 1'b0;
			stall_left <= 2'd0;
			wait_left <= 2'd0;
			o_ack <= 1'b0;
			o_err <= 1'b0;
			o_data <= '0;
			for (int i = 0; i < 256; i++)
			begin
				gmem[i] <= fill_word(1'b0, i[7:0]);
				lmem[i] <= fill_word(1'b1, i[7:0]);
			end
		end else begin
			o_ack <= 1'b0;
			o_err <= 1'b0;
			if (!busy)
			begin
				if (stb_in && stall_left != 2'd0)
					stall_left <= stall_left - 2'd1;
				else if (stb_in)
				begin
					// Strobe taken
					busy <= 1'b1;
					wait_left <= $urandom % 4;
					is_lcl <= lcl_req;
					is_err <= gbl_req && (i_addr[29:22] == 8'h04);
					we_q <= i_we;
					addr_q <= i_addr;
					data_q <= i_data;
					sel_q <= i_sel;
				end
			end else if (wait_left != 2'd0)
				wait_left <= wait_left - 2'd1;
			else begin
				busy <= 1'b0;
				stall_left <= $urandom % 4;
				if (is_err)
					o_err <= 1'b1;
				else begin
					o_ack <= 1'b1;
					o_data <= cur;
					if (we_q && is_lcl)
						lmem[addr_q[7:0]] <= merged;
					else if (we_q)
						gmem[addr_q[7:0]] <= merged;
				end
			end
		end
	end

endmodule

// ==== tb_zip_bus.sv ====
////////////////////
// Testbench for the CPU bus side
// Fetch, load, store, bus error and arbitration cases from a table,
// served by a Wishbone slave model with random stalls and delays
////////////////////

`timescale 1ns/1ns

module tb_zip_bus;
	import zip_bus_pkg::*;

	// Table entry kinds
	localparam logic [1:0] K_FETCH = 2'd0;
	localparam logic [1:0] K_REDIRECT = 2'd1;
	localparam logic [1:0] K_MEM = 2'd2;
	localparam logic [1:0] K_BOTH = 2'd3;
	// Conditions a wait loop can wait on
	localparam int W_PF_VALID = 0;
	localparam int W_MEM_DONE = 1;
	localparam int W_MEM_IDLE = 2;
	localparam int W_BUS_STB = 3;
	localparam int W_FETCH_CYC = 4;
	localparam int TIMEOUT = 200;
	localparam int MAX_TESTS = 24;

	logic		i_clk;
	logic		i_reset;
	logic		i_pf_new_pc;
	byte_addr_t	i_pf_pc;
	logic		i_pf_ready;
	logic		o_pf_valid;
	logic		o_pf_illegal;
	word_t		o_pf_insn;
	byte_addr_t	o_pf_pc;
	logic		i_mem_ce;
	mem_op_t	i_mem_op;
	byte_addr_t	i_mem_addr;
	word_t		i_mem_data;
	reg_id_t	i_mem_reg;
	logic		o_mem_busy;
	logic		o_mem_valid;
	logic		o_mem_err;
	reg_id_t	o_mem_wreg;
	word_t		o_mem_result;
	logic		o_wb_gbl_cyc;
	logic		o_wb_gbl_stb;
	logic		o_wb_lcl_cyc;
	logic		o_wb_lcl_stb;
	logic		o_wb_we;
	wb_addr_t	o_wb_addr;
	word_t		o_wb_data;
	sel_t		o_wb_sel;
	logic		i_wb_stall;
	logic		i_wb_ack;
	logic		i_wb_err;
	word_t		i_wb_data;

	// Stimulus and expectation table
	string		t_name [MAX_TESTS];
	logic [1:0]	t_kind [MAX_TESTS];
	mem_op_t	t_op [MAX_TESTS];
	byte_addr_t	t_addr [MAX_TESTS];
	// Store data, or the second PC for fetch kinds
	word_t		t_data [MAX_TESTS];
	reg_id_t	t_reg [MAX_TESTS];
	int		t_count [MAX_TESTS];
	word_t		t_exp [MAX_TESTS];
	logic		t_err [MAX_TESTS];
	int		n_tests = 0;

	zip_bus_top DUT (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_pf_new_pc(i_pf_new_pc), .i_pf_pc(i_pf_pc), .i_pf_ready(i_pf_ready),
		.o_pf_valid(o_pf_valid), .o_pf_illegal(o_pf_illegal),
		.o_pf_insn(o_pf_insn), .o_pf_pc(o_pf_pc),
		.i_mem_ce(i_mem_ce), .i_mem_op(i_mem_op), .i_mem_addr(i_mem_addr),
		.i_mem_data(i_mem_data), .i_mem_reg(i_mem_reg),
		.o_mem_busy(o_mem_busy), .o_mem_valid(o_mem_valid), .o_mem_err(o_mem_err),
		.o_mem_wreg(o_mem_wreg), .o_mem_result(o_mem_result),
		.o_wb_gbl_cyc(o_wb_gbl_cyc), .o_wb_gbl_stb(o_wb_gbl_stb),
		.o_wb_lcl_cyc(o_wb_lcl_cyc), .o_wb_lcl_stb(o_wb_lcl_stb),
		.o_wb_we(o_wb_we), .o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data), .o_wb_sel(o_wb_sel),
		.i_wb_stall(i_wb_stall), .i_wb_ack(i_wb_ack),
		.i_wb_err(i_wb_err), .i_wb_data(i_wb_data)
	);

	zip_wb_slave_model slave (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_gbl_cyc(o_wb_gbl_cyc), .i_gbl_stb(o_wb_gbl_stb),
		.i_lcl_cyc(o_wb_lcl_cyc), .i_lcl_stb(o_wb_lcl_stb),
		.i_we(o_wb_we), .i_addr(o_wb_addr), .i_data(o_wb_data), .i_sel(o_wb_sel),
		.o_stall(i_wb_stall), .o_ack(i_wb_ack), .o_err(i_wb_err), .o_data(i_wb_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	////////////////////
	// Expected values
	////////////////////

	// Memory content after reset, same rule as the slave model
	function automatic word_t model_word(input logic lcl, input logic [7:0] idx);
		model_word = {lcl ? 8'hc3 : 8'h3c, idx, ~idx, idx ^ 8'h96};
	endfunction

	// Big-endian lane of an unwritten word, zero-extended
	function automatic word_t expect_load(input mem_op_t op, input byte_addr_t addr);
		word_t w;
		w = model_word(addr[31:24] == LCL_PREFIX, addr[9:2]);
		case (op)
		MEM_LH: expect_load = addr[1] ? {16'h0, w[15:0]} : {16'h0, w[31:16]};
		MEM_LB:
			case (addr[1:0])
			2'd0: expect_load = {24'h0, w[31:24]};
			2'd1: expect_load = {24'h0, w[23:16]};
			2'd2: expect_load = {24'h0, w[15:8]};
			default: expect_load = {24'h0, w[7:0]};
			endcase
		default: expect_load = w;
		endcase
	endfunction

	task automatic add_test(input string name, input logic [1:0] kind, input mem_op_t op,
		input byte_addr_t addr, input word_t data, input reg_id_t rg, input int count,
		input word_t exp, input logic err);
		t_name[n_tests] = name;
		t_kind[n_tests] = kind;
		t_op[n_tests] = op;
		t_addr[n_tests] = addr;
		t_data[n_tests] = data;
		t_reg[n_tests] = rg;
		t_count[n_tests] = count;
		t_exp[n_tests] = exp;
		t_err[n_tests] = err;
		n_tests++;
	endtask

	////////////////////
	// Checks
	////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_reg(input string name, input reg_id_t exp, input reg_id_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	// Sample at the falling edge until the condition holds
	task automatic wait_for(input int what, input string name);
		int n;
		logic met;
		n = 0;
		met = 1'b0;
		while (!met)
		begin
			@(negedge i_clk);
			case (what)
			W_PF_VALID: met = o_pf_valid;
			W_MEM_DONE: met = o_mem_valid || o_mem_err;
			W_MEM_IDLE: met = !o_mem_busy;
			W_BUS_STB: met = o_wb_gbl_stb || o_wb_lcl_stb;
			default: met = o_wb_gbl_cyc;
			endcase
			n++;
			if (!met && n > TIMEOUT)
				fail_run($sformatf("Timeout in %s, the DUT did not answer within %0d cycles",
					name, TIMEOUT));
		end
	endtask

	////////////////////
	// Drivers
	////////////////////

	// One-cycle new PC pulse
	task automatic issue_pc(input byte_addr_t pc);
		@(posedge i_clk);
		i_pf_new_pc <= 1'b1;
		i_pf_pc <= pc;
		@(posedge i_clk);
		i_pf_new_pc <= 1'b0;
	endtask

	// Core accepts the held word after a random back-pressure delay
	task automatic consume_insn(input string name);
		logic rdy;
		int n;
		rdy = 1'b0;
		n = 0;
		while (!rdy)
		begin
			rdy = $urandom % 2;
			@(posedge i_clk);
			i_pf_ready <= rdy;
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("Timeout in %s, ready was never offered", name));
		end
		@(posedge i_clk);
		i_pf_ready <= 1'b0;
	endtask

	task automatic start_mem(input int t, input logic with_fetch);
		@(posedge i_clk);
		i_mem_ce <= 1'b1;
		i_mem_op <= t_op[t];
		i_mem_addr <= t_addr[t];
		i_mem_data <= t_data[t];
		i_mem_reg <= t_reg[t];
		if (with_fetch)
		begin
			i_pf_new_pc <= 1'b1;
			i_pf_pc <= t_data[t];
		end
		@(posedge i_clk);
		i_mem_ce <= 1'b0;
		i_pf_new_pc <= 1'b0;
	endtask

	task automatic check_fetch(input string name, input byte_addr_t pc, input logic err);
		check_word({name, " pc"}, pc, o_pf_pc);
		check_flag({name, " illegal"}, err, o_pf_illegal);
		if (!err)
			check_word({name, " insn"}, model_word(1'b0, pc[9:2]), o_pf_insn);
	endtask

	task automatic check_load(input int t);
		wait_for(W_MEM_DONE, t_name[t]);
		check_flag({t_name[t], " err"}, t_err[t], o_mem_err);
		check_flag({t_name[t], " valid"}, !t_err[t], o_mem_valid);
		check_flag({t_name[t], " busy"}, 1'b0, o_mem_busy);
		if (t_err[t])
		begin
			// Nothing may follow the error pulse
			@(negedge i_clk);
			check_flag({t_name[t], " late valid"}, 1'b0, o_mem_valid);
		end else begin
			check_word({t_name[t], " result"}, t_exp[t], o_mem_result);
			check_reg({t_name[t], " wreg"}, t_reg[t], o_mem_wreg);
		end
	endtask

	////////////////////
	// Test kinds
	////////////////////

	task automatic run_fetch(input int t);
		byte_addr_t pc;
		issue_pc(t_addr[t]);
		pc = t_addr[t];
		if (t_kind[t] == K_REDIRECT)
		begin
			// Second PC lands while the first fetch is on the bus
			wait_for(W_FETCH_CYC, t_name[t]);
			issue_pc(t_data[t]);
			pc = t_data[t];
		end
		for (int k = 0; k < t_count[t]; k++)
		begin
			wait_for(W_PF_VALID, t_name[t]);
			check_fetch(t_name[t], pc, t_err[t]);
			consume_insn(t_name[t]);
			pc = pc + INSN_BYTES;
		end
	endtask

	task automatic run_mem(input int t);
		start_mem(t, 1'b0);
		if (t_op[t] == MEM_SW || t_op[t] == MEM_SH || t_op[t] == MEM_SB)
		begin
			wait_for(W_MEM_IDLE, t_name[t]);
			check_flag({t_name[t], " store valid"}, 1'b0, o_mem_valid);
		end else
			check_load(t);
	endtask

	// Data and fetch in the same cycle, data must reach the bus first
	task automatic run_both(input int t);
		start_mem(t, 1'b1);
		wait_for(W_BUS_STB, t_name[t]);
		check_word({t_name[t], " first addr"}, {2'b00, t_addr[t][31:2]}, {2'b00, o_wb_addr});
		check_load(t);
		wait_for(W_PF_VALID, t_name[t]);
		check_fetch(t_name[t], t_data[t], 1'b0);
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		word_t merged;
		void'($urandom(32'h81ee_40c5));
		i_reset <= 1'b1;
		i_pf_new_pc <= 1'b0;
		i_pf_pc <= '0;
		i_pf_ready <= 1'b0;
		i_mem_ce <= 1'b0;
		i_mem_op <= MEM_LW;
		i_mem_addr <= '0;
		i_mem_data <= '0;
		i_mem_reg <= '0;

		add_test("fetch_seq", K_FETCH, MEM_LW, 32'h0000_0100, '0, '0, 6, '0, 1'b0);
		add_test("fetch_redirect", K_REDIRECT, MEM_LW, 32'h0000_0300, 32'h0000_0040,
			'0, 2, '0, 1'b0);
		add_test("fetch_err", K_FETCH, MEM_LW, 32'h0400_0010, '0, '0, 1, '0, 1'b1);
		add_test("load_w", K_MEM, MEM_LW, 32'h0000_0200, '0, 5'd3, 1,
			expect_load(MEM_LW, 32'h0000_0200), 1'b0);
		for (int i = 0; i < 4; i += 2)
			add_test($sformatf("load_h%0d", i), K_MEM, MEM_LH, 32'h0000_0204 + i, '0,
				5'd4 + i, 1, expect_load(MEM_LH, 32'h0000_0204 + i), 1'b0);
		for (int i = 0; i < 4; i++)
			add_test($sformatf("load_b%0d", i), K_MEM, MEM_LB, 32'h0000_0208 + i, '0,
				5'd8 + i, 1, expect_load(MEM_LB, 32'h0000_0208 + i), 1'b0);
		add_test("lcl_load_w", K_MEM, MEM_LW, 32'hff00_0300, '0, 5'd20, 1,
			expect_load(MEM_LW, 32'hff00_0300), 1'b0);
		add_test("lcl_load_h", K_MEM, MEM_LH, 32'hff00_0306, '0, 5'd21, 1,
			expect_load(MEM_LH, 32'hff00_0306), 1'b0);
		add_test("lcl_load_b", K_MEM, MEM_LB, 32'hff00_0305, '0, 5'd22, 1,
			expect_load(MEM_LB, 32'hff00_0305), 1'b0);

		// Byte at offset 1 and halfword at offset 2 land in their own lanes
		merged = model_word(1'b0, 8'ha0);
		merged = {merged[31:24], 8'hab, 16'hcdef};
		add_test("store_b", K_MEM, MEM_SB, 32'h0000_0281, 32'h1234_56ab, '0, 1, '0, 1'b0);
		add_test("store_h", K_MEM, MEM_SH, 32'h0000_0282, 32'h9876_cdef, '0, 1, '0, 1'b0);
		add_test("store_merge", K_MEM, MEM_LW, 32'h0000_0280, '0, 5'd30, 1, merged, 1'b0);
		add_test("mem_err", K_MEM, MEM_LW, 32'h0400_0100, '0, 5'd31, 1, '0, 1'b1);
		add_test("arbitrate", K_BOTH, MEM_LW, 32'h0000_0210, 32'h0000_0020, 5'd17, 1,
			expect_load(MEM_LW, 32'h0000_0210), 1'b0);

		repeat (10) @(posedge i_clk);
		i_reset <= 1'b0;

		for (int t = 0; t < n_tests; t++)
		begin
			case (t_kind[t])
			K_FETCH, K_REDIRECT: run_fetch(t);
			K_MEM: run_mem(t);
			default: run_both(t);
			endcase
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== zip_bus_top.f ====
zip_bus_pkg.sv
zip_wb_if.sv
zip_prefetch.sv
zip_memops.sv
zip_bus_arbiter.sv
zip_bus_top.sv
zip_wb_slave_model.sv
tb_zip_bus.sv
